// File: source/cpuPkg.sv
// Shared widths, encodings and instruction layout for the 16-bit core; imported by every block
`default_nettype none

package cpuPkg;

  localparam int dataWidth    = 16;  // Register and bus width
  localparam int regAddrWidth = 3;   // Eight registers
  localparam int pcWidth      = 12;  // Instruction address width

  // Flag vector layout
  localparam int flagCount    = 4;
  localparam int flagZero     = 0;
  localparam int flagNegative = 1;
  localparam int flagCarry    = 2;
  localparam int flagOverflow = 3;

  typedef enum logic [1:0] {
    jumpClass     = 2'b00,
    constFiClass  = 2'b01,  // Wide constant into r7
    aluClass      = 2'b10,
    constFiiClass = 2'b11   // Byte constant
  } opClass;

  typedef enum logic [4:0] {
    opAdd        = 5'd0,
    opSub        = 5'd1,
    opAnd        = 5'd2,
    opOr         = 5'd3,
    opXor        = 5'd4,
    opNotA       = 5'd5,
    opShiftLeft  = 5'd6,
    opShiftRight = 5'd7,
    opMove       = 5'd8,
    opLoad       = 5'd10,
    opStore      = 5'd11
  } aluOp;

  typedef enum logic [1:0] {
    jumpFalse    = 2'b00,
    jumpTrue     = 2'b01,
    jumpAbsolute = 2'b10,
    jumpReserved = 2'b11   // Link and register jumps, treated as no-op
  } jumpKind;

  // Register write data source
  typedef enum logic [1:0] {
    fromAlu    = 2'b00,
    fromMemory = 2'b01,
    fromImm11  = 2'b10,
    fromImm8   = 2'b11
  } writeSel;

  typedef enum logic [1:0] {
    stateFetch     = 2'b00,
    stateDecode    = 2'b01,
    stateExecute   = 2'b10,
    stateWriteback = 2'b11
  } stateCode;

  typedef union packed {
    struct packed {
      opClass                  instrClass;
      logic [regAddrWidth-1:0] dest;
      aluOp                    op;
      logic [regAddrWidth-1:0] srcA;
      logic [regAddrWidth-1:0] srcB;
    } alu;
    struct packed {
      opClass      instrClass;
      logic [2:0]  spare;
      logic [10:0] imm11;
    } fi;
    struct packed {
      opClass                  instrClass;
      logic [regAddrWidth-1:0] dest;
      logic                    highByte;  // Selects bits 15:8
      logic [1:0]              spare;
      logic [7:0]              imm8;
    } fii;
    struct packed {
      opClass     instrClass;
      jumpKind    kind;
      logic [3:0] condition;  // Flag index, 4 and up is always true
      logic [7:0] offset;     // Absolute target uses condition and offset
    } jump;
  } instructionWord;

endpackage

`default_nettype wire

// File: source/controlBus.sv
// Control bundle from the controller to the datapath blocks, carrying memory and flag returns
`timescale 1ns/1ps
`default_nettype none

interface controlBus;
  import cpuPkg::*;

  // Register file
  logic                    regWrite;
  logic [regAddrWidth-1:0] regDest;
  logic                    highByteWrite;
  logic [regAddrWidth-1:0] srcA;
  logic [regAddrWidth-1:0] srcB;
  writeSel                 writeSource;  // Selected in the core

  // ALU
  aluOp                    aluOperation;
  logic                    flagUpdate;
  logic [flagCount-1:0]    flags;        // Returned by the ALU

  // Program counter
  logic                    pcLoadRelative;
  logic                    pcLoadAbsolute;
  logic                    pcIncrement;
  logic [7:0]              jumpOffset;   // Also the imm8 field
  logic [pcWidth-1:0]      jumpTarget;   // Also carries imm11

  // Data bus
  logic                    memRequest;
  logic                    memWrite;
  logic                    memDone;      // One-cycle pulse on ack

  modport controlSide (
    output regWrite, regDest, highByteWrite, srcA, srcB, writeSource,
    output aluOperation, flagUpdate,
    output pcLoadRelative, pcLoadAbsolute, pcIncrement, jumpOffset, jumpTarget,
    output memRequest, memWrite,
    input  memDone, flags
  );
  modport registerSide (input regWrite, regDest, highByteWrite, srcA, srcB);
  modport aluSide (input aluOperation, flagUpdate, output flags);
  modport pcSide (input pcLoadRelative, pcLoadAbsolute, pcIncrement, jumpOffset, jumpTarget);
  modport memorySide (input memRequest, memWrite, output memDone);

endinterface

`default_nettype wire

// File: source/controlUnit.sv
// Four-state multicycle controller; holds the instruction register and drives the control bundle
`timescale 1ns/1ps
`default_nettype none

module controlUnit (
  input  logic                         clock,
  input  logic                         arstN,
  input  logic                         run,
  input  logic [cpuPkg::dataWidth-1:0] instrData,
  controlBus.controlSide               ctrl
);
  import cpuPkg::*;

  stateCode       state;
  stateCode       nextState;
  instructionWord ir;
  logic           isMemOp;
  logic           conditionMet;
  logic           jumpTaken;

  always_ff @(posedge clock or negedge arstN) begin
    if (!arstN) begin
      state <= stateFetch;
      ir    <= '0;
    end else begin
      state <= nextState;
      if (state == stateDecode) begin
        ir <= instrData;  // Memory output is valid in decode
      end
    end
  end

  assign isMemOp = (ir.alu.instrClass == aluClass) &&
                   ((ir.alu.op == opLoad) || (ir.alu.op == opStore));

  // Jump condition from the selected flag
  always_comb begin
    if (ir.jump.condition < flagCount) begin
      conditionMet = ctrl.flags[ir.jump.condition[1:0]];
    end else begin
      conditionMet = 1'b1;
    end
    case (ir.jump.kind)
      jumpTrue:  jumpTaken = conditionMet;
      jumpFalse: jumpTaken = !conditionMet;
      default:   jumpTaken = 1'b0;
    endcase
  end

  always_comb begin
    nextState           = state;
    ctrl.regWrite       = 1'b0;
    ctrl.regDest        = ir.alu.dest;
    ctrl.highByteWrite  = 1'b0;
    ctrl.srcA           = ir.alu.srcA;
    ctrl.srcB           = ir.alu.srcB;
    ctrl.writeSource    = fromAlu;
    ctrl.aluOperation   = ir.alu.op;
    ctrl.flagUpdate     = 1'b0;
    ctrl.pcLoadRelative = 1'b0;
    ctrl.pcLoadAbsolute = 1'b0;
    ctrl.pcIncrement    = 1'b0;
    ctrl.jumpOffset     = ir.jump.offset;
    ctrl.jumpTarget     = {ir.jump.condition, ir.jump.offset};
    ctrl.memRequest     = 1'b0;
    ctrl.memWrite       = (ir.alu.op == opStore);

    case (state)
      stateFetch: begin
        if (run) begin
          nextState = stateDecode;  // Otherwise hold here
        end
      end
      stateDecode: begin
        nextState = stateExecute;
      end
      stateExecute: begin
        if (isMemOp) begin
          ctrl.memRequest = 1'b1;
          if (ctrl.memDone) begin
            nextState = stateWriteback;
          end
        end else begin
          ctrl.flagUpdate = (ir.alu.instrClass == aluClass);
          nextState       = stateWriteback;
        end
      end
      stateWriteback: begin
        nextState = stateFetch;
        case (ir.alu.instrClass)
          aluClass: begin
            ctrl.regWrite    = (ir.alu.op != opStore);
            ctrl.writeSource = (ir.alu.op == opLoad) ? fromMemory : fromAlu;
            ctrl.pcIncrement = 1'b1;
          end
          constFiClass: begin
            ctrl.regWrite    = 1'b1;
            ctrl.regDest     = '1;  // FI always targets r7
            ctrl.writeSource = fromImm11;
            ctrl.pcIncrement = 1'b1;
          end
          constFiiClass: begin
            ctrl.regWrite      = 1'b1;
            ctrl.regDest       = ir.fii.dest;
            ctrl.highByteWrite = ir.fii.highByte;
            ctrl.writeSource   = fromImm8;
            ctrl.pcIncrement   = 1'b1;
          end
          default: begin
            if (ir.jump.kind == jumpAbsolute) begin
              ctrl.pcLoadAbsolute = 1'b1;
            end else if (jumpTaken) begin
              ctrl.pcLoadRelative = 1'b1;
            end else begin
              ctrl.pcIncrement = 1'b1;  // Not taken or reserved
            end
          end
        endcase
      end
      default: begin
        nextState = stateFetch;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: source/registerFile.sv
// Eight-entry register file with two combinational read ports and a byte-merging write port
`timescale 1ns/1ps
`default_nettype none

module registerFile (
  input  logic                         clock,
  input  logic                         arstN,
  controlBus.registerSide              ctrl,
  input  logic [cpuPkg::dataWidth-1:0] writeData,
  output logic [cpuPkg::dataWidth-1:0] readA,
  output logic [cpuPkg::dataWidth-1:0] readB
);
  import cpuPkg::*;

  logic [dataWidth-1:0] regs [2**regAddrWidth];

  always_ff @(posedge clock or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < 2**regAddrWidth; i++) begin
        regs[i] <= '0;
      end
    end else if (ctrl.regWrite) begin
      if (ctrl.highByteWrite) begin
        // Low byte kept for the high-byte constant
        regs[ctrl.regDest][dataWidth-1:dataWidth/2] <= writeData[dataWidth-1:dataWidth/2];
      end else begin
        regs[ctrl.regDest] <= writeData;
      end
    end
  end

  assign readA = regs[ctrl.srcA];  // Address for memory ops
  assign readB = regs[ctrl.srcB];  // Store data for memory ops

endmodule

`default_nettype wire

// File: source/aluUnit.sv
// Combinational ALU with a flag register updated at the end of execute
`timescale 1ns/1ps
`default_nettype none

module aluUnit (
  input  logic                         clock,
  input  logic                         arstN,
  controlBus.aluSide                   ctrl,
  input  logic [cpuPkg::dataWidth-1:0] operandA,
  input  logic [cpuPkg::dataWidth-1:0] operandB,
  output logic [cpuPkg::dataWidth-1:0] result
);
  import cpuPkg::*;

  logic [dataWidth:0] sum;
  logic [dataWidth:0] diff;
  logic               carryOut;
  logic               overflowOut;

  assign sum  = {1'b0, operandA} + {1'b0, operandB};
  assign diff = {1'b0, operandA} - {1'b0, operandB};  // Top bit is the borrow

  always_comb begin
    result      = '0;
    carryOut    = 1'b0;
    overflowOut = 1'b0;
    case (ctrl.aluOperation)
      opAdd: begin
        result      = sum[dataWidth-1:0];
        carryOut    = sum[dataWidth];
        overflowOut = (operandA[dataWidth-1] == operandB[dataWidth-1]) &&
                      (sum[dataWidth-1] != operandA[dataWidth-1]);
      end
      opSub: begin
        result      = diff[dataWidth-1:0];
        carryOut    = diff[dataWidth];
        overflowOut = (operandA[dataWidth-1] != operandB[dataWidth-1]) &&
                      (diff[dataWidth-1] != operandA[dataWidth-1]);
      end
      opAnd:  result = operandA & operandB;
      opOr:   result = operandA | operandB;
      opXor:  result = operandA ^ operandB;
      opNotA: result = ~operandA;
      opShiftLeft: begin
        result   = {operandA[dataWidth-2:0], 1'b0};
        carryOut = operandA[dataWidth-1];  // Bit shifted out
      end
      opShiftRight: begin
        result   = {1'b0, operandA[dataWidth-1:1]};
        carryOut = operandA[0];
      end
      opMove: result = operandA;
      default: result = '0;  // Load, store and unused codes
    endcase
  end

  always_ff @(posedge clock or negedge arstN) begin
    if (!arstN) begin
      ctrl.flags <= '0;
    end else if (ctrl.flagUpdate) begin
      ctrl.flags[flagZero]     <= (result == '0);
      ctrl.flags[flagNegative] <= result[dataWidth-1];
      ctrl.flags[flagCarry]    <= carryOut;
      ctrl.flags[flagOverflow] <= overflowOut;
    end
  end

endmodule

`default_nettype wire

// File: source/programCounter.sv
// Program counter stepping at the end of writeback, with relative and absolute jumps
`timescale 1ns/1ps
`default_nettype none

module programCounter (
  input  logic                       clock,
  input  logic                       arstN,
  controlBus.pcSide                  ctrl,
  output logic [cpuPkg::pcWidth-1:0] pc
);
  import cpuPkg::*;

  logic [pcWidth-1:0] pcStep;
  logic [pcWidth-1:0] offsetExtended;

  assign pcStep = pc + 1'b1;

  // Sign-extend the 8-bit branch offset
  assign offsetExtended = {{(pcWidth-8){ctrl.jumpOffset[7]}}, ctrl.jumpOffset};

  always_ff @(posedge clock or negedge arstN) begin
    if (!arstN) begin
      pc <= '0;
    end else if (ctrl.pcLoadAbsolute) begin
      pc <= ctrl.jumpTarget;
    end else if (ctrl.pcLoadRelative) begin
      pc <= pcStep + offsetExtended;  // Relative to the next instruction
    end else if (ctrl.pcIncrement) begin
      pc <= pcStep;
    end
  end

endmodule

`default_nettype wire

// File: source/dataBusMaster.sv
// Wishbone classic master performing a single load or store per controller request
`timescale 1ns/1ps
`default_nettype none

module dataBusMaster (
  input  logic                         clock,
  input  logic                         arstN,
  controlBus.memorySide                ctrl,
  input  logic [cpuPkg::dataWidth-1:0] address,
  input  logic [cpuPkg::dataWidth-1:0] writeData,
  output logic [cpuPkg::dataWidth-1:0] readData,
  output logic                         wbCyc,
  output logic                         wbStb,
  output logic                         wbWe,
  output logic [cpuPkg::dataWidth-1:0] wbAdr,
  output logic [cpuPkg::dataWidth-1:0] wbDatOut,
  input  logic [cpuPkg::dataWidth-1:0] wbDatIn,
  input  logic                         wbAck
);

  logic busy;  // Low is idle, high holds the cycle

  always_ff @(posedge clock or negedge arstN) begin
    if (!arstN) begin
      busy <= 1'b0;
      wbWe <= 1'b0;
    end else if (!busy) begin
      if (ctrl.memRequest) begin
        busy <= 1'b1;
        wbWe <= ctrl.memWrite;
      end
    end else if (wbAck) begin
      busy <= 1'b0;
      wbWe <= 1'b0;
    end
  end

  // Address and data stay stable for the whole cycle
  always_ff @(posedge clock) begin
    if (!busy && ctrl.memRequest) begin
      wbAdr    <= address;
      wbDatOut <= writeData;
    end
    if (busy && wbAck && !wbWe) begin
      readData <= wbDatIn;  // Read data sampled on ack
    end
  end

  assign wbCyc        = busy;
  assign wbStb        = busy;
  assign ctrl.memDone = busy && wbAck;

endmodule

`default_nettype wire

// File: source/cpuCore.sv
// Top level of the multicycle core with instruction and Wishbone data ports
`timescale 1ns/1ps
`default_nettype none

module cpuCore (
  input  logic                         clock,
  input  logic                         arstN,
  input  logic                         run,
  output logic [cpuPkg::pcWidth-1:0]   instrAddr,
  input  logic [cpuPkg::dataWidth-1:0] instrData,
  output logic                         wbCyc,
  output logic                         wbStb,
  output logic                         wbWe,
  output logic [cpuPkg::dataWidth-1:0] wbAdr,
  output logic [cpuPkg::dataWidth-1:0] wbDatOut,
  input  logic [cpuPkg::dataWidth-1:0] wbDatIn,
  input  logic                         wbAck
);
  import cpuPkg::*;

  logic [dataWidth-1:0] readA;
  logic [dataWidth-1:0] readB;
  logic [dataWidth-1:0] aluResult;
  logic [dataWidth-1:0] loadData;
  logic [dataWidth-1:0] writeData;
  logic [pcWidth-1:0]   pc;

  controlBus ctrl ();

  assign instrAddr = pc;

  // Write data select; constants come from the low instruction fields
  always_comb begin
    case (ctrl.writeSource)
      fromMemory: writeData = loadData;
      fromImm11:  writeData = {{(dataWidth-11){1'b0}}, ctrl.jumpTarget[10:0]};
      fromImm8: begin
        if (ctrl.highByteWrite) begin
          writeData = {ctrl.jumpOffset, {(dataWidth-8){1'b0}}};
        end else begin
          writeData = {{(dataWidth-8){1'b0}}, ctrl.jumpOffset};
        end
      end
      default:    writeData = aluResult;
    endcase
  end

  controlUnit controlUnit_inst (
    .clock     (clock),
    .arstN     (arstN),
    .run       (run),
    .instrData (instrData),
    .ctrl      (ctrl)
  );

  registerFile registerFile_inst (
    .clock     (clock),
    .arstN     (arstN),
    .ctrl      (ctrl),
    .writeData (writeData),
    .readA     (readA),
    .readB     (readB)
  );

  aluUnit aluUnit_inst (
    .clock    (clock),
    .arstN    (arstN),
    .ctrl     (ctrl),
    .operandA (readA),
    .operandB (readB),
    .result   (aluResult)
  );

  programCounter programCounter_inst (
    .clock (clock),
    .arstN (arstN),
    .ctrl  (ctrl),
    .pc    (pc)
  );

  dataBusMaster dataBusMaster_inst (
    .clock     (clock),
    .arstN     (arstN),
    .ctrl      (ctrl),
    .address   (readA),
    .writeData (readB),
    .readData  (loadData),
    .wbCyc     (wbCyc),
    .wbStb     (wbStb),
    .wbWe      (wbWe),
    .wbAdr     (wbAdr),
    .wbDatOut  (wbDatOut),
    .wbDatIn   (wbDatIn),
    .wbAck     (wbAck)
  );

endmodule

`default_nettype wire

// File: verification/cpuCore_properties.sv
// Wishbone protocol and reset checks for the core, attached to cpuCore by bind from the testbench
`timescale 1ns/1ps
`default_nettype none

module cpuCore_properties (
  input logic                         clock,
  input logic                         arstN,
  input logic                         wbCyc,
  input logic                         wbStb,
  input logic                         wbWe,
  input logic                         wbAck,
  input logic [cpuPkg::dataWidth-1:0] wbAdr,
  input logic [cpuPkg::dataWidth-1:0] wbDatOut
);

  // Strobe only inside a cycle
  stbInsideCyc: assert property (@(posedge clock) disable iff (!arstN) wbStb |-> wbCyc)
    else $error("wbStb high without wbCyc");

  // Request must hold until the slave acks
  requestHeld: assert property (@(posedge clock) disable iff (!arstN)
    (wbStb && !wbAck) |=> ($stable(wbAdr) && $stable(wbWe) && $stable(wbDatOut)))
    else $error("Wishbone request changed before wbAck");

  idleAfterReset: assert property (@(posedge clock) $rose(arstN) |=> !wbCyc)
    else $error("wbCyc high in the cycle after reset release");  // Bus quiet after reset

endmodule

`default_nettype wire

// File: verification/cpuCoreTb.sv
// Testbench for the core; runs a table of short programs on memory models and checks the first store
`timescale 1ns/1ps
`default_nettype none

module cpuCoreTb;
  import cpuPkg::*;

  localparam int caseLimit    = 8;
  localparam int storeTimeout = 200;  // Cycles

  logic         clock;
  logic         arstN;
  logic         run;
  logic [11:0]  instrAddr;
  logic [15:0]  instrData = 16'h0000;
  logic         wbCyc;
  logic         wbStb;
  logic         wbWe;
  logic [15:0]  wbAdr;
  logic [15:0]  wbDatOut;
  logic [15:0]  wbDatIn = 16'h0000;
  logic         wbAck = 1'b0;
  logic [15:0]  imem [8];
  logic [15:0]  dmem [4];
  logic [127:0] programs [caseLimit];
  logic [63:0]  dataWords [caseLimit];
  logic [15:0]  expAdr [caseLimit];
  logic [15:0]  expVal [caseLimit];
  int           maxWaits [caseLimit];
  int           idleCycles [caseLimit];
  int           caseCount;
  int           maxWait;
  int           waitLeft;
  int           storeCount;
  int           errorCount;
  logic [15:0]  firstAdr;
  logic [15:0]  firstVal;
  logic [11:0]  fetchAddr;
  logic         inReset;
  logic         stbSeen;

  cpuCore cpuCore_inst (
    .clock     (clock),
    .arstN     (arstN),
    .run       (run),
    .instrAddr (instrAddr),
    .instrData (instrData),
    .wbCyc     (wbCyc),
    .wbStb     (wbStb),
    .wbWe      (wbWe),
    .wbAdr     (wbAdr),
    .wbDatOut  (wbDatOut),
    .wbDatIn   (wbDatIn),
    .wbAck     (wbAck)
  );

  bind cpuCore cpuCore_properties cpuCore_properties_inst (.*);

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  function automatic logic [15:0] aluWord(input aluOp op, input int dest, input int a, input int b);
    return {aluClass, dest[2:0], op, a[2:0], b[2:0]};
  endfunction

  function automatic logic [15:0] fiWord(input logic [10:0] imm);
    return {constFiClass, 3'b000, imm};
  endfunction

  function automatic logic [15:0] fiiWord(input int dest, input logic high, input logic [7:0] imm);
    return {constFiiClass, dest[2:0], high, 2'b00, imm};
  endfunction

  function automatic logic [15:0] jumpWord(input jumpKind kind, input int cond,
                                           input logic [7:0] offset);
    return {jumpClass, kind, cond[3:0], offset};
  endfunction

  function automatic logic [15:0] absJumpWord(input logic [11:0] target);
    return {jumpClass, jumpAbsolute, target};
  endfunction

  function automatic logic [15:0] readWord(input logic [15:0] addr);
    if (addr < 16'd4) begin
      return dmem[addr[1:0]];
    end
    return (addr * 16'h9e37) ^ 16'h3c5a;  // Fill outside the loaded words
  endfunction

  task automatic stopOnError();
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic checkValue(input string name, input logic [15:0] actual,
                            input logic [15:0] expected);
    if (actual !== expected) begin
      errorCount++;
      $display("Mismatch at %0t: %s is %h, expected %h", $time, name, actual, expected);
      stopOnError();
    end
  endtask

  task automatic addCase(input logic [127:0] code, input logic [63:0] data,
                         input logic [15:0] adr, input logic [15:0] val,
                         input int waits, input int idle);
    programs[caseCount]   = code;
    dataWords[caseCount]  = data;
    expAdr[caseCount]     = adr;
    expVal[caseCount]     = val;
    maxWaits[caseCount]   = waits;
    idleCycles[caseCount] = idle;
    caseCount++;
  endtask

  task automatic buildTable();
    logic [127:0] loadProgram;
    loadProgram = {fiiWord(1, 1'b0, 8'h02), aluWord(opLoad, 2, 1, 0), fiiWord(3, 1'b0, 8'h11),
                   aluWord(opAdd, 4, 2, 3), fiiWord(5, 1'b0, 8'h40), aluWord(opStore, 0, 5, 4),
                   absJumpWord(12'd6), 16'h0000};
    // Byte constants, add, shift left, xor; run held low for 20 cycles first
    addCase({fiiWord(1, 1'b0, 8'h34), fiiWord(1, 1'b1, 8'h12), fiiWord(2, 1'b0, 8'h0f),
             aluWord(opAdd, 3, 1, 2), aluWord(opShiftLeft, 3, 3, 0), aluWord(opXor, 3, 3, 1),
             aluWord(opStore, 0, 2, 3), absJumpWord(12'd7)}, 64'h0, 16'h000f, 16'h36b2, 2, 20);
    addCase({fiWord(11'd5), fiiWord(1, 1'b0, 8'h03), aluWord(opSub, 2, 1, 7),
             aluWord(opShiftRight, 2, 2, 0), fiiWord(3, 1'b0, 8'h20), aluWord(opStore, 0, 3, 2),
             absJumpWord(12'd6), 16'h0000}, 64'h0, 16'h0020, 16'h7fff, 2, 2);
    addCase(loadProgram, 64'h1111_2222_3456_4444, 16'h0040, 16'h3467, 4, 2);
    // Zero set: true taken, false not taken
    addCase({aluWord(opSub, 1, 0, 0), jumpWord(jumpTrue, flagZero, 8'd1),
             fiiWord(2, 1'b0, 8'hee), jumpWord(jumpFalse, flagZero, 8'd1),
             fiiWord(2, 1'b1, 8'h5a), aluWord(opStore, 0, 0, 2), absJumpWord(12'd6), 16'h0000},
            64'h0, 16'h0000, 16'h5a00, 2, 2);
    // Carry and negative set
    addCase({fiiWord(1, 1'b0, 8'h01), aluWord(opSub, 2, 0, 1),
             jumpWord(jumpFalse, flagCarry, 8'd1), fiiWord(3, 1'b0, 8'h11),
             jumpWord(jumpTrue, flagNegative, 8'd1), fiiWord(3, 1'b1, 8'hee),
             aluWord(opStore, 0, 0, 3), absJumpWord(12'd7)}, 64'h0, 16'h0000, 16'h0011, 2, 2);
    // All flags clear: true not taken, false taken
    addCase({fiiWord(1, 1'b0, 8'h01), aluWord(opAdd, 2, 1, 1),
             jumpWord(jumpTrue, flagZero, 8'd1), fiiWord(3, 1'b0, 8'h22),
             jumpWord(jumpFalse, flagCarry, 8'd1), fiiWord(3, 1'b1, 8'hee),
             aluWord(opStore, 0, 0, 3), absJumpWord(12'd7)}, 64'h0, 16'h0000, 16'h0022, 2, 2);
    // Negative flag must survive the load
    addCase({fiiWord(1, 1'b0, 8'h03), aluWord(opSub, 2, 0, 1), aluWord(opLoad, 3, 1, 0),
             absJumpWord(12'd5), aluWord(opStore, 0, 1, 3),
             jumpWord(jumpTrue, flagNegative, 8'd1), aluWord(opStore, 0, 1, 3),
             aluWord(opStore, 0, 0, 3)}, 64'h0101_0202_0303_beef, 16'h0000, 16'hbeef, 2, 2);
    addCase(loadProgram, 64'h1111_2222_3456_4444, 16'h0040, 16'h3467, 12, 2);  // Long waits
  endtask

  // Instruction memory with a registered read
  always @(posedge clock) begin
    fetchAddr = instrAddr;
    #2;
    instrData = (fetchAddr < 12'd8) ? imem[fetchAddr[2:0]] : 16'h0000;
  end

  // Wishbone slave, samples at the edge and answers 2 ns later
  initial begin
    void'($urandom(32'h3f88));  // Fixed seed for the wait-state sequence
    forever begin
      @(posedge clock);
      inReset = !arstN;
      stbSeen = wbStb;
      #2;
      if (inReset) begin
        wbAck      = 1'b0;
        storeCount = 0;
        waitLeft   = $urandom % (maxWait + 1);
      end else if (wbAck) begin
        wbAck = 1'b0;
      end else if (stbSeen && waitLeft > 0) begin
        waitLeft--;
      end else if (stbSeen) begin
        if (wbWe) begin
          storeCount++;
          if (storeCount == 1) begin
            firstAdr = wbAdr;
            firstVal = wbDatOut;
          end
        end else begin
          wbDatIn = readWord(wbAdr);
        end
        wbAck    = 1'b1;
        waitLeft = $urandom % (maxWait + 1);
      end
    end
  end

  initial begin
    int row;
    int cycles;
    arstN      = 1'b0;
    run        = 1'b0;
    errorCount = 0;
    caseCount  = 0;
    maxWait    = 0;
    buildTable();
    for (row = 0; row < caseCount; row++) begin
      @(posedge clock);
      #2;
      arstN   = 1'b0;
      run     = 1'b0;
      maxWait = maxWaits[row];
      for (int i = 0; i < 8; i++) begin
        imem[i] = programs[row][(7-i)*16 +: 16];
      end
      for (int i = 0; i < 4; i++) begin
        dmem[i] = dataWords[row][(3-i)*16 +: 16];
      end
      repeat (3) @(posedge clock);
      #2;
      arstN = 1'b1;
      repeat (idleCycles[row]) begin
        @(negedge clock);
        checkValue("wbCyc", {15'b0, wbCyc}, 16'h0000);
        checkValue("instrAddr", {4'b0, instrAddr}, 16'h0000);
      end
      @(posedge clock);
      #2;
      run    = 1'b1;
      cycles = 0;
      while (storeCount == 0 && cycles < storeTimeout) begin
        @(negedge clock);
        cycles++;
      end
      if (storeCount == 0) begin
        $display("Timeout: case %0d made no store within %0d cycles", row, storeTimeout);
        stopOnError();
      end
      checkValue("wbAdr", firstAdr, expAdr[row]);
      checkValue("wbDatOut", firstVal, expVal[row]);
      repeat (maxWait + 10) @(negedge clock);
      checkValue("storeCount", storeCount[15:0], 16'd1);  // No repeated store
    end
    if (errorCount == 0) begin
      $display("Regression passed");
      $finish;
    end else begin
      stopOnError();
    end
  end

endmodule

`default_nettype wire

// File: sources.f
source/cpuPkg.sv
source/controlBus.sv
source/controlUnit.sv
source/registerFile.sv
source/aluUnit.sv
source/programCounter.sv
source/dataBusMaster.sv
source/cpuCore.sv
verification/cpuCore_properties.sv
verification/cpuCoreTb.sv
